// File: list.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/alu.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/ex_stage.sv
verif/ex_stage_chk.sv
verif/tb_ex_stage.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the ex_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_ex_stage \
    -f list.f -o sim_ex_stage \
    && ./obj_dir/sim_ex_stage | tee sim.log \
    && grep -qx "All checks passed" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: verif/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

    typedef struct packed {
        isa_pkg::alu_op_t   alu_op;
        isa_pkg::md_op_t    md_op;
        isa_pkg::mem_op_t   mem_op;
        isa_pkg::word_t     src1;
        isa_pkg::word_t     src2;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     exp_res;
        logic               exp_ale;
        logic               do_flush;
    } entry_t;

    localparam int max_ent    = 32;
    localparam int wait_limit = 200;

    logic              clk = 1'b0;
    logic              rst;
    logic              flush;
    logic              in_valid;
    pipe_pkg::id_ex_t  in_bundle;
    logic              allowin;
    logic              out_valid;
    pipe_pkg::ex_mem_t out_bundle;
    logic              out_ready;
    pipe_pkg::fwd_t    fwd;
    logic              is_load;
    isa_pkg::dword_t   counter;

    entry_t      tbl [max_ent];
    string       names [max_ent];
    int          n_ent = 0;
    int          cyc = 0;
    int          errors = 0;
    int          tests = 0;
    int          test_err;
    logic [31:0] lfsr = 32'h78b9;
    int          acc_q[$];

    ex_stage u_dut (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_bundle  (in_bundle),
        .allowin    (allowin),
        .out_valid  (out_valid),
        .out_bundle (out_bundle),
        .out_ready  (out_ready),
        .fwd        (fwd),
        .is_load    (is_load),
        .counter    (counter)
    );

    bind ex_stage ex_stage_chk u_chk (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .allowin    (allowin),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // free-running stable counter
    always @(posedge clk) begin
        #1;
        counter = counter + 64'd1;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic is_ld_op(input isa_pkg::mem_op_t op);
        return op inside {isa_pkg::mem_ld_b, isa_pkg::mem_ld_bu, isa_pkg::mem_ld_h,
                          isa_pkg::mem_ld_hu, isa_pkg::mem_ld_w};
    endfunction

    function automatic logic is_st_op(input isa_pkg::mem_op_t op);
        return op inside {isa_pkg::mem_st_b, isa_pkg::mem_st_h, isa_pkg::mem_st_w};
    endfunction

    function automatic isa_pkg::word_t entry_pc(input int pass, input int i);
        return 32'h1c00_0000 + 32'(pass * 256) + 32'(i * 4);
    endfunction

    task automatic add_entry(input string nm, input isa_pkg::alu_op_t aop,
                             input isa_pkg::md_op_t mop, input isa_pkg::mem_op_t mem,
                             input isa_pkg::word_t s1, input isa_pkg::word_t s2,
                             input isa_pkg::word_t res, input logic ale, input logic fl);
        tbl[n_ent]   = '{aop, mop, mem, s1, s2, 5'(n_ent + 1), res, ale, fl};
        names[n_ent] = nm;
        n_ent++;
    endtask

    task automatic compare(input string nm, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected %08h actual %08h", nm, exp, act);
            errors++;
            test_err++;
        end
    endtask

    task automatic drive_all(input int pass);
        int  waited;
        logic accepted;
        // line up with the input timing after the previous pass
        @(posedge clk);
        #1;
        for (int i = 0; i < n_ent; i++) begin
            in_bundle.pc      = entry_pc(pass, i);
            in_bundle.inst    = 32'h0280_0000 + 32'(i);
            in_bundle.src1    = tbl[i].src1;
            in_bundle.src2    = tbl[i].src2;
            in_bundle.alu_op  = tbl[i].alu_op;
            in_bundle.md_op   = tbl[i].md_op;
            in_bundle.mem_op  = tbl[i].mem_op;
            in_bundle.gr_we   = ~is_st_op(tbl[i].mem_op);
            in_bundle.dest    = tbl[i].dest;
            in_bundle.st_data = 32'h5a00_0000 + 32'(i);
            in_valid = 1'b1;
            waited   = 0;
            accepted = 1'b0;
            while (!accepted && waited < wait_limit) begin
                @(negedge clk);
                if (allowin) begin
                    accepted = 1'b1;
                    if (!tbl[i].do_flush) begin
                        acc_q.push_back(cyc + 1);
                    end
                end else begin
                    @(posedge clk);
                    #1;
                    waited++;
                end
            end
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            if (!accepted) begin
                $display("timed out waiting for allowin on %s", names[i]);
                errors++;
                return;
            end
            // drop the divide while it is still iterating
            if (tbl[i].do_flush) begin
                repeat (4) @(posedge clk);
                #1 flush = 1'b1;
                @(posedge clk);
                #1 flush = 1'b0;
            end
        end
    endtask

    task automatic check_all(input int pass);
        int   waited;
        int   first;
        int   acc;
        logic got;
        logic seen;
        logic exp_fwd;
        for (int i = 0; i < n_ent; i++) begin
            if (tbl[i].do_flush) begin
                continue;
            end
            test_err = 0;
            waited   = 0;
            got      = 1'b0;
            seen     = 1'b0;
            first    = 0;
            while (!got && waited < wait_limit) begin
                @(posedge clk);
                #1;
                if (pass == 0) begin
                    out_ready = 1'b1;
                end else begin
                    lfsr      = lfsr_next(lfsr);
                    out_ready = lfsr[0];
                end
                @(negedge clk);
                if (out_valid && !seen) begin
                    seen  = 1'b1;
                    first = cyc;
                end
                if (out_valid && out_ready) begin
                    got = 1'b1;
                end
                waited++;
            end
            tests++;
            if (!got) begin
                $display("timed out waiting for the result of %s", names[i]);
                errors++;
                return;
            end
            acc = acc_q.pop_front();
            exp_fwd = ~is_st_op(tbl[i].mem_op) & ~is_ld_op(tbl[i].mem_op);
            compare({names[i], ".pc"}, entry_pc(pass, i), out_bundle.pc);
            compare({names[i], ".inst"}, 32'h0280_0000 + 32'(i), out_bundle.inst);
            compare({names[i], ".mem_op"}, {28'd0, tbl[i].mem_op}, {28'd0, out_bundle.mem_op});
            compare({names[i], ".gr_we"}, {31'd0, ~is_st_op(tbl[i].mem_op)},
                    {31'd0, out_bundle.gr_we});
            compare({names[i], ".result"}, tbl[i].exp_res, out_bundle.result);
            compare({names[i], ".ale"}, {31'd0, tbl[i].exp_ale}, {31'd0, out_bundle.ale});
            compare({names[i], ".dest"}, {27'd0, tbl[i].dest}, {27'd0, out_bundle.dest});
            compare({names[i], ".st_data"}, 32'h5a00_0000 + 32'(i), out_bundle.st_data);
            compare({names[i], ".is_load"}, {31'd0, is_ld_op(tbl[i].mem_op)}, {31'd0, is_load});
            compare({names[i], ".fwd_valid"}, {31'd0, exp_fwd}, {31'd0, fwd.valid});
            if (exp_fwd) begin
                compare({names[i], ".fwd_dest"}, {27'd0, tbl[i].dest}, {27'd0, fwd.dest});
                compare({names[i], ".fwd_data"}, tbl[i].exp_res, fwd.data);
            end
            // single-cycle classes: valid one edge after acceptance
            if (pass == 0 && tbl[i].md_op inside {isa_pkg::md_none, isa_pkg::md_mul,
                                                  isa_pkg::md_mulh, isa_pkg::md_mulhu}) begin
                compare({names[i], ".latency"}, 32'(acc + 1), 32'(first));
            end
            if (test_err == 0) begin
                $display("pass %0d %s ok", pass, names[i]);
            end else begin
                $display("pass %0d %s had %0d errors", pass, names[i], test_err);
            end
        end
        out_ready = 1'b1;
    endtask

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_bundle = '0;
        out_ready = 1'b0;
        counter   = '0;

        add_entry("add_carry", isa_pkg::alu_add, isa_pkg::md_none, isa_pkg::mem_none,
                  32'hffff_ffff, 32'h2, 32'h1, 1'b0, 1'b0);
        add_entry("sub_neg", isa_pkg::alu_sub, isa_pkg::md_none, isa_pkg::mem_none,
                  32'h5, 32'h7, 32'hffff_fffe, 1'b0, 1'b0);
        add_entry("slt_mixed", isa_pkg::alu_slt, isa_pkg::md_none, isa_pkg::mem_none,
                  32'hffff_ffff, 32'h1, 32'h1, 1'b0, 1'b0);
        add_entry("sltu_mixed", isa_pkg::alu_sltu, isa_pkg::md_none, isa_pkg::mem_none,
                  32'hffff_ffff, 32'h1, 32'h0, 1'b0, 1'b0);
        add_entry("sll_31", isa_pkg::alu_sll, isa_pkg::md_none, isa_pkg::mem_none,
                  32'h1, 32'd31, 32'h8000_0000, 1'b0, 1'b0);
        add_entry("srl_31", isa_pkg::alu_srl, isa_pkg::md_none, isa_pkg::mem_none,
                  32'h8000_0000, 32'd31, 32'h1, 1'b0, 1'b0);
        add_entry("sra_31", isa_pkg::alu_sra, isa_pkg::md_none, isa_pkg::mem_none,
                  32'h8000_0000, 32'd31, 32'hffff_ffff, 1'b0, 1'b0);
        add_entry("nor", isa_pkg::alu_nor, isa_pkg::md_none, isa_pkg::mem_none,
                  32'h0000_ffff, 32'h00ff_0000, 32'hff00_0000, 1'b0, 1'b0);
        add_entry("lui", isa_pkg::alu_lui, isa_pkg::md_none, isa_pkg::mem_none,
                  32'h0, 32'h1234_5000, 32'h1234_5000, 1'b0, 1'b0);
        add_entry("mul_neg", isa_pkg::alu_add, isa_pkg::md_mul, isa_pkg::mem_none,
                  32'hffff_fffe, 32'h3, 32'hffff_fffa, 1'b0, 1'b0);
        add_entry("mulh_neg", isa_pkg::alu_add, isa_pkg::md_mulh, isa_pkg::mem_none,
                  32'hffff_fffe, 32'h3, 32'hffff_ffff, 1'b0, 1'b0);
        add_entry("mulhu_big", isa_pkg::alu_add, isa_pkg::md_mulhu, isa_pkg::mem_none,
                  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe, 1'b0, 1'b0);
        add_entry("div_neg", isa_pkg::alu_add, isa_pkg::md_div, isa_pkg::mem_none,
                  32'hffff_fff9, 32'h2, 32'hffff_fffd, 1'b0, 1'b0);
        add_entry("mod_neg", isa_pkg::alu_add, isa_pkg::md_mod, isa_pkg::mem_none,
                  32'hffff_fff9, 32'h2, 32'hffff_ffff, 1'b0, 1'b0);
        add_entry("divu", isa_pkg::alu_add, isa_pkg::md_divu, isa_pkg::mem_none,
                  32'd100, 32'd7, 32'd14, 1'b0, 1'b0);
        add_entry("modu", isa_pkg::alu_add, isa_pkg::md_modu, isa_pkg::mem_none,
                  32'd100, 32'd7, 32'd2, 1'b0, 1'b0);
        add_entry("div_zero", isa_pkg::alu_add, isa_pkg::md_div, isa_pkg::mem_none,
                  32'd5, 32'd0, 32'hffff_ffff, 1'b0, 1'b0);
        add_entry("modu_zero", isa_pkg::alu_add, isa_pkg::md_modu, isa_pkg::mem_none,
                  32'd5, 32'd0, 32'd5, 1'b0, 1'b0);
        add_entry("div_ovf", isa_pkg::alu_add, isa_pkg::md_div, isa_pkg::mem_none,
                  32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b0, 1'b0);
        add_entry("mod_ovf", isa_pkg::alu_add, isa_pkg::md_mod, isa_pkg::mem_none,
                  32'h8000_0000, 32'hffff_ffff, 32'h0, 1'b0, 1'b0);
        add_entry("div_flushed", isa_pkg::alu_add, isa_pkg::md_divu, isa_pkg::mem_none,
                  32'd1000, 32'd3, 32'd333, 1'b0, 1'b1);
        add_entry("ld_w_odd", isa_pkg::alu_add, isa_pkg::md_none, isa_pkg::mem_ld_w,
                  32'h1000, 32'h2, 32'h1002, 1'b1, 1'b0);
        add_entry("ld_hu_even", isa_pkg::alu_add, isa_pkg::md_none, isa_pkg::mem_ld_hu,
                  32'h1000, 32'h2, 32'h1002, 1'b0, 1'b0);
        add_entry("st_h_odd", isa_pkg::alu_add, isa_pkg::md_none, isa_pkg::mem_st_h,
                  32'h1000, 32'h1, 32'h1001, 1'b1, 1'b0);
        add_entry("ld_b_any", isa_pkg::alu_add, isa_pkg::md_none, isa_pkg::mem_ld_b,
                  32'h1000, 32'h3, 32'h1003, 1'b0, 1'b0);
        add_entry("add_tail", isa_pkg::alu_add, isa_pkg::md_none, isa_pkg::mem_none,
                  32'h10, 32'h20, 32'h30, 1'b0, 1'b0);

        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        // pass 1 runs with random back-pressure
        for (int pass = 0; pass < 2; pass++) begin
            fork
                drive_all(pass);
                check_all(pass);
            join
        end

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verif/ex_stage_chk.sv
`timescale 1ns/1ps

module ex_stage_chk (
    input logic              clk,
    input logic              rst,
    input logic              flush,
    input logic              allowin,
    input logic              out_valid,
    input logic              out_ready,
    input pipe_pkg::ex_mem_t out_bundle
);

    // held output must not move under back-pressure
    bundle_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready && !flush |=> $stable(out_bundle))
        else $error("out_bundle changed while stalled");

    // with a result on offer, a new item gets in only as it leaves
    ready_allows_in: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (allowin == out_ready))
        else $error("allowin does not follow out_ready");

    flush_clears: assert property (@(posedge clk) disable iff (rst)
        flush |=> !out_valid && allowin)
        else $error("stage not empty after flush");

    reset_state: assert property (@(posedge clk)
        rst |=> !out_valid && allowin)
        else $error("stage not empty after reset");

endmodule

// File: logic/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              in_valid,
    input  pipe_pkg::id_ex_t  in_bundle,
    output logic              allowin,
    output logic              out_valid,
    output pipe_pkg::ex_mem_t out_bundle,
    input  logic              out_ready,
    output pipe_pkg::fwd_t    fwd,
    output logic              is_load,
    input  isa_pkg::dword_t   counter
);

    typedef enum logic [1:0] {
        st_empty,
        st_compute,
        st_div_wait,
        st_ready
    } stage_t;

    stage_t           state;
    pipe_pkg::id_ex_t held;
    isa_pkg::dword_t  cnt_q;
    isa_pkg::dword_t  prod;
    isa_pkg::word_t   alu_y;
    isa_pkg::word_t   quo;
    isa_pkg::word_t   rem;
    isa_pkg::word_t   result;
    logic             accept;
    logic             out_fire;
    logic             is_div;
    logic             is_ld;
    logic             res_final;
    logic             div_start;
    logic             div_busy;
    logic             div_done;
    logic             ale;

    assign out_valid = (state == st_ready);
    assign out_fire  = out_valid & out_ready;
    assign allowin   = (state == st_empty) | out_fire;
    assign accept    = in_valid & allowin;

    assign is_div = held.md_op inside {isa_pkg::md_div, isa_pkg::md_mod,
                                       isa_pkg::md_divu, isa_pkg::md_modu};
    assign is_ld  = held.mem_op inside {isa_pkg::mem_ld_b, isa_pkg::mem_ld_bu,
                                        isa_pkg::mem_ld_h, isa_pkg::mem_ld_hu,
                                        isa_pkg::mem_ld_w};

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= in_bundle;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= st_empty;
        end else begin
            case (state)
                st_empty: begin
                    if (accept) begin
                        state <= st_compute;
                    end
                end
                st_compute: begin
                    if (!is_div) begin
                        state <= st_ready;
                    end else if (!div_busy) begin
                        state <= st_div_wait;
                    end
                end
                st_div_wait: begin
                    if (div_done) begin
                        state <= st_ready;
                    end
                end
                st_ready: begin
                    if (out_fire) begin
                        state <= accept ? st_compute : st_empty;
                    end
                end
                default: state <= st_empty;
            endcase
        end
    end

    // counter frozen so the result holds under back-pressure
    always_ff @(posedge clk) begin
        if (state == st_compute) begin
            cnt_q <= counter;
        end
    end

    assign div_start = (state == st_compute) & is_div & ~div_busy;

    alu u_alu (
        .op (held.alu_op),
        .a  (held.src1),
        .b  (held.src2),
        .y  (alu_y)
    );

    mul_unit u_mul (
        .clk         (clk),
        .rst         (rst),
        .a           (held.src1),
        .b           (held.src2),
        .is_unsigned (held.md_op == isa_pkg::md_mulhu),
        .prod        (prod)
    );

    div_unit u_div (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .abort     (flush),
        .is_signed (held.md_op inside {isa_pkg::md_div, isa_pkg::md_mod}),
        .dividend  (held.src1),
        .divisor   (held.src2),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (quo),
        .remainder (rem)
    );

    always_comb begin
        case (held.md_op)
            isa_pkg::md_mul:     result = prod[31:0];
            isa_pkg::md_mulh,
            isa_pkg::md_mulhu:   result = prod[63:32];
            isa_pkg::md_div,
            isa_pkg::md_divu:    result = quo;
            isa_pkg::md_mod,
            isa_pkg::md_modu:    result = rem;
            isa_pkg::md_rdcntvl: result = cnt_q[31:0];
            isa_pkg::md_rdcntvh: result = cnt_q[63:32];
            default:             result = alu_y;
        endcase
    end

    // alu_y is the effective address for loads and stores
    always_comb begin
        case (held.mem_op)
            isa_pkg::mem_ld_w,
            isa_pkg::mem_st_w:  ale = |alu_y[1:0];
            isa_pkg::mem_ld_h,
            isa_pkg::mem_ld_hu,
            isa_pkg::mem_st_h:  ale = alu_y[0];
            default:            ale = 1'b0;
        endcase
    end

    // plain alu items are final already in the compute cycle
    assign res_final = (state == st_ready)
                     | ((state == st_compute) & (held.md_op == isa_pkg::md_none));

    assign is_load = (state != st_empty) & is_ld;

    always_comb begin
        fwd.valid = res_final & held.gr_we & ~is_ld;
        fwd.dest  = held.dest;
        fwd.data  = result;
    end

    always_comb begin
        out_bundle.pc      = held.pc;
        out_bundle.inst    = held.inst;
        out_bundle.mem_op  = held.mem_op;
        out_bundle.gr_we   = held.gr_we;
        out_bundle.dest    = held.dest;
        out_bundle.result  = result;
        out_bundle.st_data = held.st_data;
        out_bundle.ale     = ale;
    end

endmodule

// File: logic/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           abort,
    input  logic           is_signed,
    input  isa_pkg::word_t dividend,
    input  isa_pkg::word_t divisor,
    output logic           busy,
    output logic           done,
    output isa_pkg::word_t quotient,
    output isa_pkg::word_t remainder
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_fix
    } div_state_t;

    div_state_t     state;
    logic [4:0]     step;
    isa_pkg::word_t abs_a;
    isa_pkg::word_t abs_b;
    isa_pkg::word_t quo;
    isa_pkg::word_t rem;
    isa_pkg::word_t dvsr;
    isa_pkg::word_t dvnd_raw;
    logic           neg_q;
    logic           neg_r;
    logic           div_zero;
    logic [32:0]    trial;
    logic [32:0]    diff;

    assign abs_a = (is_signed && dividend[31]) ? -dividend : dividend;
    assign abs_b = (is_signed && divisor[31]) ? -divisor : divisor;

    // bring down the next dividend bit and try the subtract
    assign trial = {rem, quo[31]};
    assign diff  = trial - {1'b0, dvsr};

    always_ff @(posedge clk) begin
        if (rst || abort) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                    end
                    step <= '0;
                end
                st_run: begin
                    step <= step + 5'd1;
                    if (step == 5'(isa_pkg::div_steps - 1)) begin
                        state <= st_fix;
                    end
                end
                st_fix:  state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // quo doubles as the dividend shift register
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            quo      <= abs_a;
            rem      <= '0;
            dvsr     <= abs_b;
            dvnd_raw <= dividend;
            neg_q    <= is_signed & (dividend[31] ^ divisor[31]);
            neg_r    <= is_signed & dividend[31];
            div_zero <= (divisor == '0);
        end else if (state == st_run) begin
            quo <= {quo[30:0], ~diff[32]};
            rem <= diff[32] ? trial[31:0] : diff[31:0];
        end
    end

    assign busy = (state == st_run);
    assign done = (state == st_fix);

    // sign fix-up on the way out; results hold until the next start
    assign quotient  = div_zero ? '1 : (neg_q ? -quo : quo);
    assign remainder = div_zero ? dvnd_raw : (neg_r ? -rem : rem);

endmodule

// File: logic/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
    input  logic            clk,
    input  logic            rst,
    input  isa_pkg::word_t  a,
    input  isa_pkg::word_t  b,
    input  logic            is_unsigned,
    output isa_pkg::dword_t prod
);

    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [63:0] full;

    // one extra bit lets a single signed multiplier cover mulhu
    assign a_ext = {~is_unsigned & a[31], a};
    assign b_ext = {~is_unsigned & b[31], b};

    // only the low 64 bits of the 66-bit product are kept
    assign full = 64'(a_ext) * 64'(b_ext);

    always_ff @(posedge clk) begin
        if (rst) begin
            prod <= '0;
        end else begin
            prod <= full;
        end
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  isa_pkg::alu_op_t op,
    input  isa_pkg::word_t   a,
    input  isa_pkg::word_t   b,
    output isa_pkg::word_t   y
);

    logic            use_sub;
    isa_pkg::word_t  b_in;
    logic [32:0]     sum;
    logic            lt_signed;
    logic            lt_unsigned;
    isa_pkg::shamt_t sa;

    // sub and both compares share the adder as a + ~b + 1
    assign use_sub = op inside {isa_pkg::alu_sub, isa_pkg::alu_slt, isa_pkg::alu_sltu};
    assign b_in    = use_sub ? ~b : b;
    assign sum     = {1'b0, a} + {1'b0, b_in} + {32'd0, use_sub};

    // no borrow out means a >= b unsigned
    assign lt_unsigned = ~sum[32];
    assign lt_signed   = (a[31] != b[31]) ? a[31] : sum[31];

    assign sa = b[isa_pkg::shamt_w-1:0];

    always_comb begin
        case (op)
            isa_pkg::alu_add,
            isa_pkg::alu_sub:  y = sum[31:0];
            isa_pkg::alu_slt:  y = {31'd0, lt_signed};
            isa_pkg::alu_sltu: y = {31'd0, lt_unsigned};
            isa_pkg::alu_and:  y = a & b;
            isa_pkg::alu_or:   y = a | b;
            isa_pkg::alu_nor:  y = ~(a | b);
            isa_pkg::alu_xor:  y = a ^ b;
            isa_pkg::alu_sll:  y = a << sa;
            isa_pkg::alu_srl:  y = a >> sa;
            isa_pkg::alu_sra:  y = isa_pkg::word_t'($signed(a) >>> sa);
            // upper immediate already placed by decode
            isa_pkg::alu_lui:  y = b;
            default:           y = '0;
        endcase
    end

endmodule

// File: logic/pipe_pkg.sv
package pipe_pkg;

    // decode to execute
    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::word_t     inst;
        isa_pkg::word_t     src1;
        isa_pkg::word_t     src2;
        isa_pkg::alu_op_t   alu_op;
        isa_pkg::md_op_t    md_op;
        isa_pkg::mem_op_t   mem_op;
        logic               gr_we;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     st_data;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::word_t     inst;
        isa_pkg::mem_op_t   mem_op;
        logic               gr_we;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     result;
        isa_pkg::word_t     st_data;
        logic               ale;
    } ex_mem_t;

    // bypass back to decode
    typedef struct packed {
        logic               valid;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     data;
    } fwd_t;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

    localparam int word_w     = 32;
    localparam int dword_w    = 64;
    localparam int reg_addr_w = 5;
    localparam int shamt_w    = 5;

    // one restoring step per quotient bit
    localparam int div_steps  = 32;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [dword_w-1:0]    dword_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [shamt_w-1:0]    shamt_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_nor  = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_t;

    // picks the unit whose result the stage forwards
    typedef enum logic [3:0] {
        md_none    = 4'd0,
        md_mul     = 4'd1,
        md_mulh    = 4'd2,
        md_mulhu   = 4'd3,
        md_div     = 4'd4,
        md_mod     = 4'd5,
        md_divu    = 4'd6,
        md_modu    = 4'd7,
        md_rdcntvl = 4'd8,
        md_rdcntvh = 4'd9
    } md_op_t;

    typedef enum logic [3:0] {
        mem_none  = 4'd0,
        mem_ld_b  = 4'd1,
        mem_ld_bu = 4'd2,
        mem_ld_h  = 4'd3,
        mem_ld_hu = 4'd4,
        mem_ld_w  = 4'd5,
        mem_st_b  = 4'd6,
        mem_st_h  = 4'd7,
        mem_st_w  = 4'd8
    } mem_op_t;

endpackage
